/* files.f */
+incdir+tb
verilog/rename_pkg.sv
verilog/ckpt_if.sv
verilog/free_list.sv
verilog/rename_table.sv
verilog/rename_unit.sv
tb/tb_rename_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rename stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wall -Wno-fatal \
    --top-module tb_rename_unit \
    -f files.f \
    -o sim_rename

./obj_dir/sim_rename > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

/* tb/rename_model.svh */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

phreg_t        m_fl   [32];     // Free-list slots, shared tail
int            m_tail;
int            m_head [4];      // Head per version
int            m_cnt  [4];      // Free count per version
int            m_vh, m_vt, m_nck;
checkpoint_ptr m_label;         // Registered label
phreg_t        m_map  [4][32];  // Speculative maps
phreg_t        m_cmap [32];     // Committed map
phreg_t        exp_src1, exp_src2, exp_dst, exp_old;
logic          exp_stall;
checkpoint_ptr exp_ckpt;

task automatic model_reset();
    for (int i = 0; i < 32; i++) m_fl[i] = phreg_t'(32 + i); // 32..63 in order
    for (int v = 0; v < 4; v++) begin
        m_head[v] = 0;
        m_cnt[v]  = 32;
        for (int r = 0; r < 32; r++) m_map[v][r] = phreg_t'(r); // Identity
    end
    for (int r = 0; r < 32; r++) m_cmap[r] = phreg_t'(r);
    m_tail  = 0;
    m_vh    = 0;
    m_vt    = 0;
    m_nck   = 0;
    m_label = '0;
endtask

// Expected outputs for the current inputs, then the state after the edge
task automatic model_cycle();
    phreg_t wr [2];
    int     n;
    int     h;
    int     nv;
    logic   need, accept, rd, ck_en;
    n = 0;
    for (int k = 0; k < 2; k++) begin
        if (req_cv[k] && req_co[k] != '0 && !req_rb) begin
            wr[n] = req_co[k]; // Lane 0 first
            n++;
        end
    end
    need      = req_dv && (req_dst != '0);
    exp_stall = req_valid && ((need && m_cnt[m_vh] == 0 && n == 0)
              || (req_br && m_nck == 3) || req_rec || req_rb);
    accept    = req_valid && !exp_stall;
    rd        = accept && need;
    ck_en     = accept && req_br;
    exp_src1  = m_map[m_vh][req_src1];
    exp_src2  = m_map[m_vh][req_src2];
    exp_old   = m_map[m_vh][req_dst];
    exp_dst   = !rd ? '0 : (m_cnt[m_vh] == 0) ? wr[0] : m_fl[m_head[m_vh]];
    exp_ckpt  = m_label;
    if (req_rb) begin
        // Every in-flight register back, committed map live again
        m_head[0] = m_tail;
        m_cnt[0]  = 32;
        m_vh      = 0;
        m_vt      = 0;
        m_nck     = 0;
        m_label   = '0;
        for (int r = 0; r < 32; r++) m_map[0][r] = m_cmap[r];
    end else begin
        for (int i = 0; i < n; i++) m_fl[(m_tail + i) % 32] = wr[i];
        m_tail = (m_tail + n) % 32;
        for (int v = 0; v < 4; v++) m_cnt[v] += n;
        for (int k = 0; k < 2; k++) begin
            if (req_cv[k] && req_ca[k] != '0) m_cmap[req_ca[k]] = req_cn[k];
        end
        m_vt    = (m_vt + req_del) % 4;
        m_label = checkpoint_ptr'(m_vh);
        if (req_rec) begin
            m_vh  = req_rc;
            m_nck = (int'(req_rc) - m_vt + 4) % 4; // Distance from oldest
        end else begin
            m_nck        = m_nck + ck_en - req_del;
            h            = (m_head[m_vh] + rd) % 32;
            m_head[m_vh] = h;
            m_cnt[m_vh]  = m_cnt[m_vh] - rd;
            if (rd) m_map[m_vh][req_dst] = exp_dst;
            if (ck_en) begin
                nv         = (m_vh + 1) % 4;
                m_head[nv] = h;
                m_cnt[nv]  = m_cnt[m_vh];
                for (int r = 0; r < 32; r++) m_map[nv][r] = m_map[m_vh][r];
                m_vh       = nv;
            end
        end
    end
endtask

`endif

/* tb/tb_rename_unit.sv */
`timescale 1ns/1ps

module tb_rename_unit;
    import rename_pkg::*;

    ////////////////////
    // Signals
    ////////////////////

    localparam int TEST_CYCLES = 170;             // Six resets plus all test steps
    localparam int LIMIT       = 2 * TEST_CYCLES; // Hang guard

    logic          clk_i = 1'b0;
    logic          rstn_i;
    logic          rename_valid, dst_valid, is_branch;
    areg_t         src1, src2, dst;
    logic [1:0]    commit_valid;
    areg_t         commit_areg [2];
    phreg_t        commit_new [2];
    phreg_t        commit_old [2];
    logic          recover, delete_ckpt, rollback;
    checkpoint_ptr recover_ckpt;
    phreg_t        src1_phreg, src2_phreg, dst_phreg, old_dst_phreg;
    checkpoint_ptr checkpoint;
    logic          rename_stall;

    // Requested inputs for the next cycle
    logic          req_valid, req_dv, req_br, req_rec, req_del, req_rb;
    areg_t         req_src1, req_src2, req_dst;
    logic [1:0]    req_cv;
    areg_t         req_ca [2];
    phreg_t        req_cn [2];
    phreg_t        req_co [2];
    checkpoint_ptr req_rc;

    // Outputs seen in the last step
    phreg_t        last_src1, last_src2, last_dst, last_old;
    logic          last_stall;
    checkpoint_ptr last_ckpt;

    int            errors = 0;
    int            checks = 0;
    int            cycles = 0;
    logic [31:0]   lfsr   = 32'd86072;

    `include "rename_model.svh"

    always #50 clk_i = ~clk_i; // 100 ns period

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    rename_unit DUT (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .rename_valid_i       (rename_valid),
        .src1_i               (src1),
        .src2_i               (src2),
        .dst_i                (dst),
        .dst_valid_i          (dst_valid),
        .is_branch_i          (is_branch),
        .commit_valid_i       (commit_valid),
        .commit_areg_i        (commit_areg),
        .commit_new_phreg_i   (commit_new),
        .commit_old_phreg_i   (commit_old),
        .recover_i            (recover),
        .recover_checkpoint_i (recover_ckpt),
        .delete_checkpoint_i  (delete_ckpt),
        .rollback_i           (rollback),
        .src1_phreg_o         (src1_phreg),
        .src2_phreg_o         (src2_phreg),
        .dst_phreg_o          (dst_phreg),
        .old_dst_phreg_o      (old_dst_phreg),
        .checkpoint_o         (checkpoint),
        .rename_stall_o       (rename_stall)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = b ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // Galois step
        return b;
    endfunction

    function automatic areg_t rand_areg();
        areg_t a;
        a = '0;
        for (int i = 0; i < 5; i++) a = {a[3:0], lfsr_bit()}; // One step per bit
        return a;
    endfunction

    function automatic areg_t rand_dst();
        areg_t a;
        a = rand_areg();
        return (a == '0) ? areg_t'(1) : a; // Never x0
    endfunction

    task automatic clear_request();
        {req_valid, req_dv, req_br, req_rec, req_del, req_rb} = '0;
        {req_src1, req_src2, req_dst} = '0;
        req_cv = '0;
        req_rc = '0;
        for (int k = 0; k < 2; k++) begin
            req_ca[k] = '0;
            req_cn[k] = '0;
            req_co[k] = '0;
        end
    endtask

    // Puts the requested inputs on the DUT ports
    task automatic drive_request();
        rename_valid <= req_valid;
        dst_valid    <= req_dv;
        is_branch    <= req_br;
        src1         <= req_src1;
        src2         <= req_src2;
        dst          <= req_dst;
        commit_valid <= req_cv;
        recover      <= req_rec;
        recover_ckpt <= req_rc;
        delete_ckpt  <= req_del;
        rollback     <= req_rb;
        for (int k = 0; k < 2; k++) begin
            commit_areg[k] <= req_ca[k];
            commit_new[k]  <= req_cn[k];
            commit_old[k]  <= req_co[k];
        end
    endtask

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("error %0t ns: %s", $time, what);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        rstn_i <= 1'b0;
        clear_request();
        drive_request();
        repeat (4) @(posedge clk_i); // Four cycles low
        rstn_i <= 1'b1;
        model_reset();
    endtask

    // Drives a cycle, checks against the model at mid-cycle and advances the model
    task automatic step();
        @(posedge clk_i);
        drive_request();
        @(negedge clk_i);
        model_cycle();
        expect_true(rename_stall == exp_stall, "rename_stall_o differs from model");
        expect_true(src1_phreg == exp_src1, "src1_phreg_o differs from model");
        expect_true(src2_phreg == exp_src2, "src2_phreg_o differs from model");
        expect_true(dst_phreg == exp_dst, "dst_phreg_o differs from model");
        expect_true(old_dst_phreg == exp_old, "old_dst_phreg_o differs from model");
        expect_true(checkpoint == exp_ckpt, "checkpoint_o differs from model");
        last_src1  = src1_phreg;
        last_src2  = src2_phreg;
        last_dst   = dst_phreg;
        last_old   = old_dst_phreg;
        last_stall = rename_stall;
        last_ckpt  = checkpoint;
        clear_request();
    endtask

    task automatic rename(input areg_t s1, input areg_t s2, input areg_t d,
                          input logic dv, input logic br);
        req_valid = 1'b1;
        req_src1  = s1;
        req_src2  = s2;
        req_dst   = d;
        req_dv    = dv;
        req_br    = br;
        step();
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_order();
        areg_t s1, s2;
        apply_reset();
        for (int i = 0; i < 32; i++) begin
            s1 = rand_areg();
            s2 = rand_areg();
            rename(s1, s2, rand_dst(), 1'b1, 1'b0);
            expect_true(last_dst == phreg_t'(32 + i), "free list order after reset");
            if (i == 0) expect_true(last_src1 == phreg_t'(s1) && last_src2 == phreg_t'(s2),
                                    "sources not identity after reset");
        end
    endtask

    task automatic test_forwarding();
        phreg_t p;
        apply_reset();
        rename(5'd1, 5'd2, 5'd5, 1'b1, 1'b0);
        p = last_dst;
        rename(5'd5, 5'd3, 5'd5, 1'b1, 1'b0);
        expect_true(last_src1 == p, "new mapping not seen next cycle");
        expect_true(last_old == p, "old destination wrong");
        p = last_dst;
        rename(5'd5, 5'd0, 5'd0, 1'b1, 1'b0); // x0 takes nothing
        expect_true(last_dst == '0, "x0 destination took a register");
        rename(5'd0, 5'd0, 5'd6, 1'b1, 1'b0);
        expect_true(last_dst == p + 1, "x0 destination consumed a register");
    endtask

    task automatic test_stall();
        apply_reset();
        for (int i = 0; i < 32; i++) rename(rand_areg(), rand_areg(), rand_dst(), 1'b1, 1'b0);
        rename(5'd1, 5'd2, 5'd9, 1'b1, 1'b0);
        expect_true(last_stall, "no stall on empty free list");
        req_cv    = 2'b01;
        req_ca[0] = 5'd20;
        req_cn[0] = 6'd40;
        req_co[0] = 6'd20;
        rename(5'd1, 5'd2, 5'd9, 1'b1, 1'b0); // Bypass of the freed register
        expect_true(!last_stall && last_dst == 6'd20, "freed register not handed out");
    endtask

    task automatic test_commit_order();
        apply_reset();
        rename(5'd0, 5'd0, 5'd10, 1'b1, 1'b0); // Takes p32
        rename(5'd0, 5'd0, 5'd11, 1'b1, 1'b0); // Takes p33
        req_cv    = 2'b11;
        req_ca[0] = 5'd10;
        req_cn[0] = 6'd32;
        req_co[0] = 6'd10;
        req_ca[1] = 5'd11;
        req_cn[1] = 6'd33;
        req_co[1] = 6'd11;
        step();
        // Thirty registers still queued ahead of the freed pair
        for (int i = 0; i < 32; i++) begin
            rename(rand_areg(), rand_areg(), rand_dst(), 1'b1, 1'b0);
            if (i == 30) expect_true(last_dst == 6'd10, "lane 0 register not reused first");
            if (i == 31) expect_true(last_dst == 6'd11, "lane 1 register not reused second");
        end
    endtask

    task automatic test_checkpoint();
        phreg_t        br_map;
        phreg_t        after_br;
        checkpoint_ptr lab;
        int            tries;
        apply_reset();
        rename(5'd0, 5'd0, 5'd3, 1'b1, 1'b0);
        rename(5'd0, 5'd0, 5'd4, 1'b1, 1'b0);
        rename(5'd0, 5'd0, 5'd3, 1'b1, 1'b1); // Branch with a destination
        br_map = last_dst;
        rename(5'd0, 5'd0, 5'd3, 1'b1, 1'b0);
        after_br = last_dst;
        lab      = last_ckpt;
        rename(5'd0, 5'd0, 5'd4, 1'b1, 1'b0);
        req_rec = 1'b1;
        req_rc  = lab;
        step();
        rename(5'd3, 5'd4, 5'd5, 1'b1, 1'b0);
        expect_true(last_src1 == br_map && last_src2 == 6'd33, "map not restored");
        expect_true(last_dst == after_br, "free list head not restored");
        for (int i = 0; i < 3; i++) rename(5'd1, 5'd2, 5'd0, 1'b0, 1'b1);
        rename(5'd1, 5'd2, 5'd0, 1'b0, 1'b1);
        expect_true(last_stall, "fourth branch not stalled");
        tries = 0;
        req_del = 1'b1;
        while (last_stall && tries < 4) begin
            rename(5'd1, 5'd2, 5'd0, 1'b0, 1'b1);
            tries++;
        end
        expect_true(!last_stall, "branch not accepted after delete");
    endtask

    task automatic test_rollback();
        apply_reset();
        rename(5'd0, 5'd0, 5'd7, 1'b1, 1'b0);
        req_cv    = 2'b01;
        req_ca[0] = 5'd7;
        req_cn[0] = last_dst;
        req_co[0] = 6'd7;
        rename(5'd0, 5'd0, 5'd8, 1'b1, 1'b0);
        req_rb = 1'b1;
        step();
        rename(5'd7, 5'd8, 5'd9, 1'b1, 1'b0);
        expect_true(last_src1 == 6'd32 && last_src2 == 6'd8, "committed map not restored");
        for (int i = 0; i < 3; i++) rename(rand_areg(), rand_areg(), rand_dst(), 1'b1, 1'b0);
    endtask

    initial begin
        rstn_i = 1'b0;
        clear_request();
        drive_request(); // Idle inputs from time zero
        test_reset_order();
        test_forwarding();
        test_stall();
        test_commit_order();
        test_checkpoint();
        test_rollback();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/ckpt_if.sv */
`timescale 1ns/1ps

interface ckpt_if;
    import rename_pkg::*;

    logic          do_checkpoint;      // Branch renamed this cycle
    logic          do_recover;         // Restore a saved version
    logic          delete_checkpoint;  // Release the oldest version
    checkpoint_ptr recover_checkpoint; // Label to restore
    logic          commit_roll_back;   // Exception, back to committed state

    // Top level drives everything
    modport ctrl (
        output do_checkpoint, do_recover, delete_checkpoint,
        output recover_checkpoint, commit_roll_back
    );

    modport fl (
        input do_checkpoint, do_recover, delete_checkpoint,
        input recover_checkpoint, commit_roll_back
    );

    modport rt (
        input do_checkpoint, do_recover, delete_checkpoint,
        input recover_checkpoint, commit_roll_back
    );

endinterface

/* verilog/free_list.sv */
`timescale 1ns/1ps

module free_list (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                read_head_i,         // Take one register
    input  logic [rename_pkg::COMMIT_WIDTH-1:0] add_free_register_i, // Per commit lane
    input  rename_pkg::phreg_t                  free_register_i [rename_pkg::COMMIT_WIDTH],
    ckpt_if.fl                                  ckpt,
    output rename_pkg::phreg_t                  new_register_o,      // Head of the list
    output rename_pkg::checkpoint_ptr           checkpoint_o,        // Label of last version
    output logic                                out_of_checkpoints_o,
    output logic                                empty_o
);
    import rename_pkg::*;

    // Every register not in the committed map can be free at once
    localparam int FL_DEPTH = NUM_PHYSICAL_REGISTERS - NUM_ISA_REGISTERS;
    localparam int PTR_W    = $clog2(FL_DEPTH);
    localparam int NW_W     = $clog2(COMMIT_WIDTH + 1);
    localparam int CK_W     = $clog2(NUM_CHECKPOINTS) + 1;

    typedef logic [PTR_W-1:0] fl_ptr_t; // Slot index
    typedef logic [PTR_W:0]   fl_cnt_t; // One bit wider, holds a full count
    typedef logic [NW_W-1:0]  nw_t;     // Writes in one cycle
    typedef logic [CK_W-1:0]  ck_cnt_t; // Outstanding checkpoints

    phreg_t        register_table [FL_DEPTH];        // Circular buffer storage
    fl_ptr_t       head           [NUM_CHECKPOINTS]; // Head per version
    fl_cnt_t       num_registers  [NUM_CHECKPOINTS]; // Free count per version
    fl_ptr_t       tail;                             // Shared by all versions

    checkpoint_ptr version_head;      // Live version
    checkpoint_ptr version_tail;      // Oldest saved version
    checkpoint_ptr version_next;
    checkpoint_ptr version_tail_next;
    ck_cnt_t       num_checkpoints;

    logic [COMMIT_WIDTH-1:0] write_en;
    fl_ptr_t       wr_slot [COMMIT_WIDTH]; // Slot for each written lane
    nw_t           n_writes;
    phreg_t        bypass_reg;             // First freed register this cycle
    logic          read_en;
    fl_cnt_t       num_current;
    fl_cnt_t       num_after;              // Live count after this cycle
    fl_ptr_t       head_after;             // Live head after this cycle

    ////////////////////
    // Freed registers
    ////////////////////

    // Register p0 is never freed and rollback drops same-cycle commits
    always_comb begin
        n_writes   = '0;
        bypass_reg = '0;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            write_en[k] = add_free_register_i[k] & (free_register_i[k] != '0)
                        & ~ckpt.commit_roll_back;
            wr_slot[k]  = tail + fl_ptr_t'(n_writes); // Lane 0 lands first
            n_writes    = n_writes + nw_t'(write_en[k]);
        end
        // Lowest enabled lane wins the bypass
        for (int k = COMMIT_WIDTH - 1; k >= 0; k--) begin
            if (write_en[k]) begin
                bypass_reg = free_register_i[k];
            end
        end
    end

    ////////////////////
    // Read and control
    ////////////////////

    assign num_current = num_registers[version_head];

    // A read needs a stored register or one freed right now
    assign read_en = read_head_i & ((num_current != '0) | (n_writes != '0))
                   & ~ckpt.do_recover & ~ckpt.commit_roll_back;

    assign num_after         = num_current + fl_cnt_t'(n_writes) - fl_cnt_t'(read_en);
    assign head_after        = head[version_head] + fl_ptr_t'(read_en);
    assign version_next      = version_head + checkpoint_ptr'(1);
    assign version_tail_next = version_tail + checkpoint_ptr'(ckpt.delete_checkpoint);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                register_table[i] <= phreg_t'(i + NUM_ISA_REGISTERS); // 32..63
            end
            for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                head[v]          <= '0;
                num_registers[v] <= fl_cnt_t'(FL_DEPTH); // Full list
            end
            tail            <= '0;
            version_head    <= '0;
            version_tail    <= '0;
            num_checkpoints <= '0;
            checkpoint_o    <= '0;
        end else if (ckpt.commit_roll_back) begin
            // All in-flight registers go back and the buffer is full again
            head[0]          <= tail;
            num_registers[0] <= fl_cnt_t'(FL_DEPTH);
            version_head     <= '0;
            version_tail     <= '0;
            num_checkpoints  <= '0;
            checkpoint_o     <= '0;
        end else begin
            for (int k = 0; k < COMMIT_WIDTH; k++) begin
                if (write_en[k]) begin
                    register_table[wr_slot[k]] <= free_register_i[k];
                end
            end
            tail <= tail + fl_ptr_t'(n_writes);

            // Freed registers count for every version
            for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                num_registers[v] <= num_registers[v] + fl_cnt_t'(n_writes);
            end

            version_tail <= version_tail_next;
            checkpoint_o <= version_head; // Label of the copy just saved

            if (ckpt.do_recover) begin
                version_head    <= ckpt.recover_checkpoint;
                // Distance from the oldest live version
                num_checkpoints <= ck_cnt_t'(checkpoint_ptr'(ckpt.recover_checkpoint
                                                            - version_tail_next));
            end else begin
                num_checkpoints <= num_checkpoints + ck_cnt_t'(ckpt.do_checkpoint)
                                 - ck_cnt_t'(ckpt.delete_checkpoint);
                head[version_head]          <= head_after;
                num_registers[version_head] <= num_after; // Overrides the loop above
                if (ckpt.do_checkpoint) begin
                    // New live version starts from the post-rename state
                    version_head                <= version_next;
                    head[version_next]          <= head_after;
                    num_registers[version_next] <= num_after;
                end
            end
        end
    end

    // Empty list hands out the freed register directly
    assign new_register_o = !read_en            ? '0 :
                            (num_current == '0) ? bypass_reg :
                                                  register_table[head[version_head]];

    assign empty_o              = (num_current == '0) & (n_writes == '0);
    assign out_of_checkpoints_o = (num_checkpoints == ck_cnt_t'(NUM_CHECKPOINTS - 1));

endmodule

/* verilog/rename_pkg.sv */
package rename_pkg;

    ////////////////////
    // Register counts
    ////////////////////

    // Architectural registers x0..x31
    localparam int NUM_ISA_REGISTERS      = 32;

    // Physical registers p0..p63
    localparam int NUM_PHYSICAL_REGISTERS = 64;

    // Map and free-list copies, one is always the live version
    localparam int NUM_CHECKPOINTS        = 4;

    // Commit slots per cycle
    localparam int COMMIT_WIDTH           = 2;

    ////////////////////
    // Index types
    ////////////////////

    // Architectural register index
    typedef logic [$clog2(NUM_ISA_REGISTERS)-1:0] areg_t;

    // Physical register index
    typedef logic [$clog2(NUM_PHYSICAL_REGISTERS)-1:0] phreg_t;

    // Checkpoint label, wraps around the copies
    typedef logic [$clog2(NUM_CHECKPOINTS)-1:0] checkpoint_ptr;

endpackage

/* verilog/rename_table.sv */
`timescale 1ns/1ps

module rename_table (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  rename_pkg::areg_t                   src1_i,      // First source
    input  rename_pkg::areg_t                   src2_i,      // Second source
    input  rename_pkg::areg_t                   dst_i,       // Destination
    input  logic                                write_dst_i, // Rename accepted with a dest
    input  rename_pkg::phreg_t                  new_dst_i,   // From the free list
    input  logic [rename_pkg::COMMIT_WIDTH-1:0] commit_valid_i,
    input  rename_pkg::areg_t                   commit_areg_i  [rename_pkg::COMMIT_WIDTH],
    input  rename_pkg::phreg_t                  commit_phreg_i [rename_pkg::COMMIT_WIDTH],
    ckpt_if.rt                                  ckpt,
    output rename_pkg::phreg_t                  src1_o,
    output rename_pkg::phreg_t                  src2_o,
    output rename_pkg::phreg_t                  old_dst_o    // Freed when this commits
);
    import rename_pkg::*;

    phreg_t        spec_map   [NUM_CHECKPOINTS][NUM_ISA_REGISTERS]; // One map per version
    phreg_t        commit_map [NUM_ISA_REGISTERS];                  // Architectural state
    checkpoint_ptr version;      // Follows the free-list version
    checkpoint_ptr version_next;

    ////////////////////
    // Lookup
    ////////////////////

    // Reads see the map before this cycle's write
    assign src1_o    = spec_map[version][src1_i];
    assign src2_o    = spec_map[version][src2_i];
    assign old_dst_o = spec_map[version][dst_i];

    assign version_next = version + checkpoint_ptr'(1);

    ////////////////////
    // Update
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            version <= '0;
            for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                    spec_map[v][r] <= phreg_t'(r); // Identity
                end
            end
            for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                commit_map[r] <= phreg_t'(r);
            end
        end else if (ckpt.commit_roll_back) begin
            // Back to committed state in version 0
            version <= '0;
            for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                spec_map[0][r] <= commit_map[r];
            end
        end else begin
            // Lane 1 is younger and wins on the same register
            for (int k = 0; k < COMMIT_WIDTH; k++) begin
                if (commit_valid_i[k] && (commit_areg_i[k] != '0)) begin
                    commit_map[commit_areg_i[k]] <= commit_phreg_i[k];
                end
            end

            if (ckpt.do_recover) begin
                version <= ckpt.recover_checkpoint; // Saved map becomes live
            end else begin
                if (write_dst_i) begin
                    spec_map[version][dst_i] <= new_dst_i;
                end
                if (ckpt.do_checkpoint) begin
                    version <= version_next;
                    // Copy includes the branch's own destination write
                    for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                        if (write_dst_i && (dst_i == areg_t'(r))) begin
                            spec_map[version_next][r] <= new_dst_i;
                        end else begin
                            spec_map[version_next][r] <= spec_map[version][r];
                        end
                    end
                end
            end
        end
    end

endmodule

/* verilog/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit (
    input  logic                                clk_i,
    input  logic                                rstn_i,

    // Rename request
    input  logic                                rename_valid_i,
    input  rename_pkg::areg_t                   src1_i,
    input  rename_pkg::areg_t                   src2_i,
    input  rename_pkg::areg_t                   dst_i,
    input  logic                                dst_valid_i,
    input  logic                                is_branch_i,  // Take a checkpoint

    // Commit lanes
    input  logic [rename_pkg::COMMIT_WIDTH-1:0] commit_valid_i,
    input  rename_pkg::areg_t                   commit_areg_i      [rename_pkg::COMMIT_WIDTH],
    input  rename_pkg::phreg_t                  commit_new_phreg_i [rename_pkg::COMMIT_WIDTH],
    input  rename_pkg::phreg_t                  commit_old_phreg_i [rename_pkg::COMMIT_WIDTH],

    // Branch and exception control
    input  logic                                recover_i,
    input  rename_pkg::checkpoint_ptr           recover_checkpoint_i,
    input  logic                                delete_checkpoint_i,
    input  logic                                rollback_i,

    // Results
    output rename_pkg::phreg_t                  src1_phreg_o,
    output rename_pkg::phreg_t                  src2_phreg_o,
    output rename_pkg::phreg_t                  dst_phreg_o,
    output rename_pkg::phreg_t                  old_dst_phreg_o,
    output rename_pkg::checkpoint_ptr           checkpoint_o,     // One cycle after the branch
    output logic                                rename_stall_o
);

    logic need_dst;     // Destination other than x0
    logic accept;       // Rename happens this cycle
    logic fl_empty;
    logic fl_no_ckpt;   // All spare versions in use
    logic dst_stall;
    logic branch_stall;

    ckpt_if ckpt_bus ();

    ////////////////////
    // Accept and stall
    ////////////////////

    assign need_dst     = dst_valid_i & (dst_i != '0);
    assign dst_stall    = need_dst & fl_empty;      // No register left
    assign branch_stall = is_branch_i & fl_no_ckpt; // Wait for a delete

    // Recover and rollback own the cycle
    assign rename_stall_o = rename_valid_i
                          & (dst_stall | branch_stall | recover_i | rollback_i);
    assign accept         = rename_valid_i & ~rename_stall_o;

    // Checkpoint control, only the branch flag is gated
    assign ckpt_bus.do_checkpoint      = accept & is_branch_i;
    assign ckpt_bus.do_recover         = recover_i;
    assign ckpt_bus.delete_checkpoint  = delete_checkpoint_i;
    assign ckpt_bus.recover_checkpoint = recover_checkpoint_i;
    assign ckpt_bus.commit_roll_back   = rollback_i;

    ////////////////////
    // Blocks
    ////////////////////

    free_list u_free_list (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .read_head_i          (accept & need_dst),
        .add_free_register_i  (commit_valid_i),
        .free_register_i      (commit_old_phreg_i),  // Old mappings become free
        .ckpt                 (ckpt_bus.fl),
        .new_register_o       (dst_phreg_o),         // Zero when nothing is taken
        .checkpoint_o         (checkpoint_o),
        .out_of_checkpoints_o (fl_no_ckpt),
        .empty_o              (fl_empty)
    );

    rename_table u_rename_table (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .src1_i         (src1_i),
        .src2_i         (src2_i),
        .dst_i          (dst_i),
        .write_dst_i    (accept & need_dst),
        .new_dst_i      (dst_phreg_o),
        .commit_valid_i (commit_valid_i),
        .commit_areg_i  (commit_areg_i),
        .commit_phreg_i (commit_new_phreg_i),    // New mappings become committed
        .ckpt           (ckpt_bus.rt),
        .src1_o         (src1_phreg_o),
        .src2_o         (src2_phreg_o),
        .old_dst_o      (old_dst_phreg_o)
    );

endmodule
